// File: testbench/core_testdata.hex
// word 0 instruction count, word 1 expected write count, then one instruction per line
// then one expected register write per line as register index and value
0000001C
0000000D
123450B7  // 00 lui  x1, 0x12345
67808113  // 04 addi x2, x1, 0x678
FFB00193  // 08 addi x3, x0, -5
00110233  // 0c add  x4, x2, x1
0041A2B3  // 10 slt  x5, x3, x4
40320333  // 14 sub  x6, x4, x3
00602423  // 18 sw   x6, 8(x0)
00802383  // 1c lw   x7, 8(x0)
0023C433  // 20 xor  x8, x7, x2
00740663  // 24 beq  x8, x7, +12 not taken
FFC18493  // 28 addi x9, x3, -4
0034C663  // 2c blt  x9, x3, +12 taken
00100513  // 30 addi x10, x0, 1 wrong path
00200513  // 34 addi x10, x0, 2 wrong path
0091C463  // 38 blt  x3, x9, +8 not taken
00802583  // 3c lw   x11, 8(x0)
00658463  // 40 beq  x11, x6, +8 taken
00700613  // 44 addi x12, x0, 7 wrong path
00C006EF  // 48 jal  x13, +12
00100713  // 4c addi x14, x0, 1 wrong path
00200713  // 50 addi x14, x0, 2 wrong path
00508013  // 54 addi x0, x1, 5
0096F7B3  // 58 and  x15, x13, x9
00F79463  // 5c bne  x15, x15, +8 not taken
00079463  // 60 bne  x15, x0, +8 taken
00900893  // 64 addi x17, x0, 9 wrong path
0097E833  // 68 or   x16, x15, x9
0000006F  // 6c jal  x0, 0
00000001 12345000
00000002 12345678
00000003 FFFFFFFB
00000004 2468A678
00000005 00000001
00000006 2468A67D
00000007 2468A67D
00000008 365CF005
00000009 FFFFFFF7
0000000B 2468A67D
0000000D 0000004C
0000000F 00000044
00000010 FFFFFFF7

// File: flist.f
source/core_pkg.sv
source/fetch_stage.sv
source/instr_decoder.sv
source/hazard_unit.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_writeback.sv
source/riscv_core.sv
testbench/tb_riscv_core.sv

// File: Makefile
.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module tb_riscv_core

sim:
	verilator --binary --timing --assert -f flist.f --top-module tb_riscv_core -o tb_riscv_core
	./obj_dir/tb_riscv_core | tee /dev/stderr | grep -qx "test passed"

clean:
	rm -rf obj_dir

// File: testbench/tb_riscv_core.sv
`default_nettype none

module tb_riscv_core;

  logic                CLK = 1'b0;
  logic                reset = 1'b1;
  core_pkg::word_t     i_mem_addr;
  core_pkg::word_t     i_mem_data;
  logic                d_mem_csn;
  logic                d_mem_wen;
  core_pkg::word_t     d_mem_addr;
  core_pkg::word_t     d_mem_wdata;
  core_pkg::word_t     d_mem_rdata;
  core_pkg::reg_addr_t rf_ra1;
  core_pkg::reg_addr_t rf_ra2;
  core_pkg::word_t     rf_rd1;
  core_pkg::word_t     rf_rd2;
  logic                rf_we;
  core_pkg::reg_addr_t rf_wa;
  core_pkg::word_t     rf_wd;

  logic [31:0]         tdata [0:127];   // raw words of the data file
  core_pkg::word_t     rom [0:63];
  core_pkg::word_t     dram [0:63];
  core_pkg::word_t     regs [0:31];
  core_pkg::reg_addr_t exp_rd [0:31];
  core_pkg::word_t     exp_val [0:31];
  int                  inst_count = 0;
  int                  exp_count = 0;
  int                  matched = 0;   // expected writes seen so far
  int                  tail = 0;      // quiet cycles after the last write
  integer              seed = 19;

  riscv_core i_dut (
    .CLK, .reset,
    .i_mem_addr, .i_mem_data,
    .d_mem_csn, .d_mem_wen, .d_mem_addr, .d_mem_wdata, .d_mem_rdata,
    .rf_ra1, .rf_ra2, .rf_rd1, .rf_rd2,
    .rf_we, .rf_wa, .rf_wd
  );

  always #2 CLK = ~CLK;

  // combinational reads, the register file gives the old value during a write
  assign i_mem_data  = rom[i_mem_addr[7:2]];
  assign d_mem_rdata = dram[d_mem_addr[7:2]];
  assign rf_rd1      = (rf_ra1 == 5'd0) ? 32'd0 : regs[rf_ra1];
  assign rf_rd2      = (rf_ra2 == 5'd0) ? 32'd0 : regs[rf_ra2];

  always @(posedge CLK)
  begin
    if (!d_mem_csn && !d_mem_wen)
      dram[d_mem_addr[7:2]] <= d_mem_wdata;
    if (rf_we)
      regs[rf_wa] <= rf_wd;
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected)
    begin
      $display("CHECK FAILED: %s is %h, expected %h at time %0t", name, actual, expected, $time);
      $display("test failed");
      $fatal(1);
    end
  endtask

  // no register write and no memory access may be seen
  task automatic check_idle();
    check_value("rf_we", {31'b0, rf_we}, 32'd0);
    check_value("d_mem_csn", {31'b0, d_mem_csn}, 32'd1);
  endtask

  task automatic take_write();
    if (matched >= exp_count)
    begin
      $display("register write to x%0d after the last expected write", rf_wa);
      $display("test failed");
      $fatal(1);
    end
    else
    begin
      check_value("rf_wa", {27'b0, rf_wa}, {27'b0, exp_rd[matched]});
      check_value("rf_wd", rf_wd, exp_val[matched]);
      matched++;
    end
  endtask

  initial
  begin
    int i;
    $readmemh("testbench/core_testdata.hex", tdata);
    inst_count = tdata[0];
    for (i = 0; i < 64; i++)
    begin
      rom[i]  = (i < inst_count) ? tdata[2 + i] : core_pkg::NOP_INST;
      dram[i] <= $random(seed);
    end
    for (i = 0; i < 32; i++)
      regs[i] <= '0;
    // pairs follow the program, register index first
    for (i = 0; i < tdata[1]; i++)
    begin
      exp_rd[i]  = tdata[2 + inst_count + 2 * i][4:0];
      exp_val[i] = tdata[3 + inst_count + 2 * i];
    end
    exp_count = tdata[1];

    for (i = 0; i < 8; i++)
    begin
      @(posedge CLK);
      if (i == 7)
        reset <= 1'b0;
      @(negedge CLK);
      check_idle();
    end
    @(negedge CLK);
    check_idle();   // first cycle out of reset

    while (matched < exp_count || tail < 20)
    begin
      @(negedge CLK);
      if (rf_we)
        take_write();
      else if (matched == exp_count)
        tail++;
    end
    $display("test passed");
    $finish;
  end

  // bound scales with the number of expected writes
  initial
  begin
    wait (exp_count > 0);
    repeat (40 * exp_count + 100) @(posedge CLK);
    $display("timeout, the core did not finish its register writes, %0d of %0d seen",
             matched, exp_count);
    $display("test failed");
    $fatal(1);
  end

endmodule

`default_nettype wire

// File: source/riscv_core.sv
`default_nettype none

module riscv_core (
  input  wire                       CLK,
  input  wire                       reset,
  output core_pkg::word_t           i_mem_addr,
  input  wire core_pkg::word_t      i_mem_data,
  output logic                      d_mem_csn,
  output logic                      d_mem_wen,
  output core_pkg::word_t           d_mem_addr,
  output core_pkg::word_t           d_mem_wdata,
  input  wire core_pkg::word_t      d_mem_rdata,
  output core_pkg::reg_addr_t       rf_ra1,
  output core_pkg::reg_addr_t       rf_ra2,
  input  wire core_pkg::word_t      rf_rd1,
  input  wire core_pkg::word_t      rf_rd2,
  output logic                      rf_we,
  output core_pkg::reg_addr_t       rf_wa,
  output core_pkg::word_t           rf_wd
);

  // fetch and hazard control
  logic                stall;
  logic                redirect;
  core_pkg::word_t     redirect_pc;
  core_pkg::word_t     if_id_inst;
  core_pkg::word_t     if_id_pc;
  core_pkg::reg_addr_t id_rs1;
  core_pkg::reg_addr_t id_rs2;
  logic                id_uses_rs1;
  logic                id_uses_rs2;
  logic                id_is_branch;
  core_pkg::fwd_sel_t  id_fwd1;
  core_pkg::fwd_sel_t  id_fwd2;
  core_pkg::fwd_sel_t  ex_fwd1;
  core_pkg::fwd_sel_t  ex_fwd2;

  // ID/EX
  core_pkg::reg_addr_t ex_rd;
  core_pkg::word_t     ex_op1;
  core_pkg::word_t     ex_op2;
  core_pkg::word_t     ex_imm;
  core_pkg::word_t     ex_link;
  core_pkg::alu_fn_t   ex_alu_fn;
  logic                ex_alu_src_imm;
  logic                ex_reg_write;
  logic                ex_mem_read;
  logic                ex_mem_write;
  core_pkg::wb_from_t  ex_wb_from;
  core_pkg::word_t     ex_result;

  // EX/MEM and MEM/WB
  core_pkg::reg_addr_t mem_rd;
  core_pkg::word_t     mem_result;
  core_pkg::word_t     mem_store_data;
  core_pkg::word_t     mem_link;
  logic                mem_reg_write;
  logic                mem_mem_read;
  logic                mem_mem_write;
  core_pkg::wb_from_t  mem_wb_from;
  core_pkg::reg_addr_t wb_rd;
  logic                wb_reg_write;
  core_pkg::word_t     wb_data;

  assign rf_we = wb_reg_write;
  assign rf_wa = wb_rd;
  assign rf_wd = wb_data;

  fetch_stage i_fetch (
    .CLK, .reset, .stall, .redirect, .redirect_pc,
    .i_mem_data, .i_mem_addr, .if_id_inst, .if_id_pc
  );

  decode_stage i_decode (
    .CLK, .reset, .stall, .if_id_inst, .if_id_pc,
    .rf_rd1, .rf_rd2, .ex_result, .mem_result, .wb_data,
    .id_fwd1, .id_fwd2, .rf_ra1, .rf_ra2,
    .id_rs1, .id_rs2, .id_uses_rs1, .id_uses_rs2, .id_is_branch,
    .redirect, .redirect_pc,
    .ex_rd, .ex_op1, .ex_op2, .ex_imm, .ex_link, .ex_alu_fn, .ex_alu_src_imm,
    .ex_reg_write, .ex_mem_read, .ex_mem_write, .ex_wb_from
  );

  execute_stage i_execute (
    .CLK, .reset,
    .ex_rd, .ex_op1, .ex_op2, .ex_imm, .ex_link, .ex_alu_fn, .ex_alu_src_imm,
    .ex_reg_write, .ex_mem_read, .ex_mem_write, .ex_wb_from,
    .ex_fwd1, .ex_fwd2, .wb_data, .ex_result,
    .mem_rd, .mem_result, .mem_store_data, .mem_link,
    .mem_reg_write, .mem_mem_read, .mem_mem_write, .mem_wb_from
  );

  memory_writeback i_mem_wb (
    .CLK, .reset,
    .mem_rd, .mem_result, .mem_store_data, .mem_link,
    .mem_reg_write, .mem_mem_read, .mem_mem_write, .mem_wb_from,
    .d_mem_rdata, .d_mem_csn, .d_mem_wen, .d_mem_addr, .d_mem_wdata,
    .wb_rd, .wb_reg_write, .wb_data
  );

  hazard_unit i_hazard (
    .CLK, .reset,
    .id_rs1, .id_rs2, .id_uses_rs1, .id_uses_rs2, .id_is_branch,
    .ex_rd, .mem_rd, .wb_rd, .ex_reg_write, .mem_reg_write, .wb_reg_write,
    .ex_mem_read, .mem_mem_read,
    .stall, .id_fwd1, .id_fwd2, .ex_fwd1, .ex_fwd2
  );

endmodule

`default_nettype wire

// File: source/memory_writeback.sv
`default_nettype none

module memory_writeback (
  input  wire                       CLK,
  input  wire                       reset,
  input  wire core_pkg::reg_addr_t  mem_rd,
  input  wire core_pkg::word_t      mem_result,
  input  wire core_pkg::word_t      mem_store_data,
  input  wire core_pkg::word_t      mem_link,
  input  wire                       mem_reg_write,
  input  wire                       mem_mem_read,
  input  wire                       mem_mem_write,
  input  wire core_pkg::wb_from_t   mem_wb_from,
  input  wire core_pkg::word_t      d_mem_rdata,
  output logic                      d_mem_csn,
  output logic                      d_mem_wen,
  output core_pkg::word_t           d_mem_addr,
  output core_pkg::word_t           d_mem_wdata,
  output core_pkg::reg_addr_t       wb_rd,
  output logic                      wb_reg_write,
  output core_pkg::word_t           wb_data
);

  core_pkg::word_t    load_word;
  core_pkg::word_t    alu_word;
  core_pkg::word_t    link_word;
  core_pkg::wb_from_t wb_from;

  assign d_mem_csn   = !(mem_mem_read || mem_mem_write);  // active low
  assign d_mem_wen   = !mem_mem_write;
  assign d_mem_addr  = mem_result;
  assign d_mem_wdata = mem_store_data;

  always_ff @(posedge CLK)
  begin
    if (reset)
      wb_reg_write <= 1'b0;
    else
      wb_reg_write <= mem_reg_write;
  end

  always_ff @(posedge CLK)
  begin
    wb_rd     <= mem_rd;
    load_word <= d_mem_rdata;
    alu_word  <= mem_result;
    link_word <= mem_link;
    wb_from   <= mem_wb_from;
  end

  always_comb
  begin
    case (wb_from)
      core_pkg::WB_MEM:  wb_data = load_word;
      core_pkg::WB_LINK: wb_data = link_word;
      default:           wb_data = alu_word;
    endcase
  end

  // decode never sets both, checked where the strobes leave the core
  mem_rw_excl: assert property (@(posedge CLK) disable iff (reset)
                                !(mem_mem_read && mem_mem_write))
    else $error("load and store flags set together");

endmodule

`default_nettype wire

// File: source/execute_stage.sv
`default_nettype none

module execute_stage (
  input  wire                       CLK,
  input  wire                       reset,
  input  wire core_pkg::reg_addr_t  ex_rd,
  input  wire core_pkg::word_t      ex_op1,
  input  wire core_pkg::word_t      ex_op2,
  input  wire core_pkg::word_t      ex_imm,
  input  wire core_pkg::word_t      ex_link,
  input  wire core_pkg::alu_fn_t    ex_alu_fn,
  input  wire                       ex_alu_src_imm,
  input  wire                       ex_reg_write,
  input  wire                       ex_mem_read,
  input  wire                       ex_mem_write,
  input  wire core_pkg::wb_from_t   ex_wb_from,
  input  wire core_pkg::fwd_sel_t   ex_fwd1,
  input  wire core_pkg::fwd_sel_t   ex_fwd2,
  input  wire core_pkg::word_t      wb_data,
  output core_pkg::word_t           ex_result,
  output core_pkg::reg_addr_t       mem_rd,
  output core_pkg::word_t           mem_result,
  output core_pkg::word_t           mem_store_data,
  output core_pkg::word_t           mem_link,
  output logic                      mem_reg_write,
  output logic                      mem_mem_read,
  output logic                      mem_mem_write,
  output core_pkg::wb_from_t        mem_wb_from
);

  core_pkg::word_t a;
  core_pkg::word_t b;       // rs2 value, also the store data
  core_pkg::word_t alu_b;

  // producers that were still in flight while this op sat in decode
  function automatic core_pkg::word_t late_fwd(input core_pkg::fwd_sel_t sel,
                                               input core_pkg::word_t op);
    case (sel)
      core_pkg::FWD_MEM: return mem_result;
      core_pkg::FWD_WB:  return wb_data;
      default:           return op;
    endcase
  endfunction

  always_comb
  begin
    a     = late_fwd(ex_fwd1, ex_op1);
    b     = late_fwd(ex_fwd2, ex_op2);
    alu_b = ex_alu_src_imm ? ex_imm : b;
    case (ex_alu_fn)
      core_pkg::ALU_SUB:   ex_result = a - alu_b;
      core_pkg::ALU_AND:   ex_result = a & alu_b;
      core_pkg::ALU_OR:    ex_result = a | alu_b;
      core_pkg::ALU_XOR:   ex_result = a ^ alu_b;
      core_pkg::ALU_SLT:   ex_result = {31'b0, $signed(a) < $signed(alu_b)};
      core_pkg::ALU_PASS2: ex_result = alu_b;
      default:             ex_result = a + alu_b;   // also load and store address
    endcase
  end

  always_ff @(posedge CLK)
  begin
    if (reset)
    begin
      mem_reg_write <= 1'b0;
      mem_mem_read  <= 1'b0;
      mem_mem_write <= 1'b0;
    end
    else
    begin
      mem_reg_write <= ex_reg_write;
      mem_mem_read  <= ex_mem_read;
      mem_mem_write <= ex_mem_write;
    end
  end

  always_ff @(posedge CLK)
  begin
    mem_rd         <= ex_rd;
    mem_result     <= ex_result;
    mem_store_data <= b;
    mem_link       <= ex_link;
    mem_wb_from    <= ex_wb_from;
  end

endmodule

`default_nettype wire

// File: source/decode_stage.sv
`default_nettype none

module decode_stage (
  input  wire                       CLK,
  input  wire                       reset,
  input  wire                       stall,
  input  wire core_pkg::word_t      if_id_inst,
  input  wire core_pkg::word_t      if_id_pc,
  input  wire core_pkg::word_t      rf_rd1,
  input  wire core_pkg::word_t      rf_rd2,
  input  wire core_pkg::word_t      ex_result,
  input  wire core_pkg::word_t      mem_result,
  input  wire core_pkg::word_t      wb_data,
  input  wire core_pkg::fwd_sel_t   id_fwd1,
  input  wire core_pkg::fwd_sel_t   id_fwd2,
  output core_pkg::reg_addr_t       rf_ra1,
  output core_pkg::reg_addr_t       rf_ra2,
  output core_pkg::reg_addr_t       id_rs1,
  output core_pkg::reg_addr_t       id_rs2,
  output logic                      id_uses_rs1,
  output logic                      id_uses_rs2,
  output logic                      id_is_branch,
  output logic                      redirect,
  output core_pkg::word_t           redirect_pc,
  output core_pkg::reg_addr_t       ex_rd,
  output core_pkg::word_t           ex_op1,
  output core_pkg::word_t           ex_op2,
  output core_pkg::word_t           ex_imm,
  output core_pkg::word_t           ex_link,
  output core_pkg::alu_fn_t         ex_alu_fn,
  output logic                      ex_alu_src_imm,
  output logic                      ex_reg_write,
  output logic                      ex_mem_read,
  output logic                      ex_mem_write,
  output core_pkg::wb_from_t        ex_wb_from
);

  core_pkg::reg_addr_t rd;
  core_pkg::word_t     imm;
  core_pkg::word_t     op1;
  core_pkg::word_t     op2;
  core_pkg::alu_fn_t   alu_fn;
  core_pkg::br_type_t  br_type;
  core_pkg::wb_from_t  wb_from;
  logic                alu_src_imm;
  logic                reg_write;
  logic                mem_read;
  logic                mem_write;

  instr_decoder i_decoder (
    .inst        (if_id_inst),
    .rs1         (id_rs1),
    .rs2         (id_rs2),
    .rd          (rd),
    .imm         (imm),
    .alu_fn      (alu_fn),
    .alu_src_imm (alu_src_imm),
    .uses_rs1    (id_uses_rs1),
    .uses_rs2    (id_uses_rs2),
    .reg_write   (reg_write),
    .mem_read    (mem_read),
    .mem_write   (mem_write),
    .br_type     (br_type),
    .wb_from     (wb_from)
  );

  function automatic core_pkg::word_t fwd_mux(input core_pkg::fwd_sel_t sel,
                                              input core_pkg::word_t rf_val);
    case (sel)
      core_pkg::FWD_EX:  return ex_result;
      core_pkg::FWD_MEM: return mem_result;
      core_pkg::FWD_WB:  return wb_data;    // rf still returns the old value
      default:           return rf_val;
    endcase
  endfunction

  assign rf_ra1       = id_rs1;
  assign rf_ra2       = id_rs2;
  assign id_is_branch = (br_type != core_pkg::BR_NONE);
  assign redirect_pc  = if_id_pc + imm;

  always_comb
  begin
    op1 = fwd_mux(id_fwd1, rf_rd1);
    op2 = fwd_mux(id_fwd2, rf_rd2);
    case (br_type)
      core_pkg::BR_EQ: redirect = (op1 == op2);
      core_pkg::BR_NE: redirect = (op1 != op2);
      core_pkg::BR_LT: redirect = ($signed(op1) < $signed(op2));
      core_pkg::BR_J:  redirect = 1'b1;
      default:         redirect = 1'b0;
    endcase
  end

  always_ff @(posedge CLK)
  begin
    if (reset || stall)   // bubble into ID/EX
    begin
      ex_reg_write <= 1'b0;
      ex_mem_read  <= 1'b0;
      ex_mem_write <= 1'b0;
    end
    else
    begin
      ex_reg_write <= reg_write;
      ex_mem_read  <= mem_read;
      ex_mem_write <= mem_write;
    end
  end

  always_ff @(posedge CLK)
  begin
    ex_rd          <= rd;
    ex_op1         <= op1;
    ex_op2         <= op2;
    ex_imm         <= imm;
    ex_link        <= if_id_pc + 32'd4;   // link of this very jal
    ex_alu_fn      <= alu_fn;
    ex_alu_src_imm <= alu_src_imm;
    ex_wb_from     <= wb_from;
  end

endmodule

`default_nettype wire

// File: source/hazard_unit.sv
`default_nettype none

module hazard_unit (
  input  wire                       CLK,
  input  wire                       reset,
  input  wire core_pkg::reg_addr_t  id_rs1,
  input  wire core_pkg::reg_addr_t  id_rs2,
  input  wire                       id_uses_rs1,
  input  wire                       id_uses_rs2,
  input  wire                       id_is_branch,
  input  wire core_pkg::reg_addr_t  ex_rd,
  input  wire core_pkg::reg_addr_t  mem_rd,
  input  wire core_pkg::reg_addr_t  wb_rd,
  input  wire                       ex_reg_write,
  input  wire                       mem_reg_write,
  input  wire                       wb_reg_write,
  input  wire                       ex_mem_read,
  input  wire                       mem_mem_read,
  output logic                      stall,
  output core_pkg::fwd_sel_t        id_fwd1,
  output core_pkg::fwd_sel_t        id_fwd2,
  output core_pkg::fwd_sel_t        ex_fwd1,
  output core_pkg::fwd_sel_t        ex_fwd2
);

  logic load_use;
  logic load_branch;

  // youngest producer first, seen from decode this cycle
  // reg_write is never set for rd zero, so x0 matches no producer
  function automatic core_pkg::fwd_sel_t id_sel(input core_pkg::reg_addr_t rs);
    if (ex_reg_write && ex_rd == rs)
      return core_pkg::FWD_EX;
    else if (mem_reg_write && mem_rd == rs)
      return core_pkg::FWD_MEM;
    else if (wb_reg_write && wb_rd == rs)
      return core_pkg::FWD_WB;
    return core_pkg::FWD_RF;
  endfunction

  // seen from execute next cycle, so each producer has moved one stage on
  function automatic core_pkg::fwd_sel_t ex_sel(input core_pkg::reg_addr_t rs);
    if (ex_reg_write && ex_rd == rs)
      return core_pkg::FWD_MEM;
    else if (mem_reg_write && mem_rd == rs)
      return core_pkg::FWD_WB;
    return core_pkg::FWD_RF;
  endfunction

  always_comb
  begin
    id_fwd1 = id_sel(id_rs1);
    id_fwd2 = id_sel(id_rs2);
  end

  always_ff @(posedge CLK)
  begin
    if (reset)
    begin
      ex_fwd1 <= core_pkg::FWD_RF;
      ex_fwd2 <= core_pkg::FWD_RF;
    end
    else
    begin
      ex_fwd1 <= ex_sel(id_rs1);
      ex_fwd2 <= ex_sel(id_rs2);
    end
  end

  assign load_use = ex_mem_read && ex_reg_write &&
                    ((id_uses_rs1 && ex_rd == id_rs1) || (id_uses_rs2 && ex_rd == id_rs2));
  // branch compares in decode, so a load one stage further still blocks it
  assign load_branch = id_is_branch && mem_mem_read && mem_reg_write &&
                       ((id_uses_rs1 && mem_rd == id_rs1) || (id_uses_rs2 && mem_rd == id_rs2));
  assign stall = load_use || load_branch;

  x0_id_fwd1: assert property (@(posedge CLK) disable iff (reset)
                               (id_rs1 == '0) |-> (id_fwd1 == core_pkg::FWD_RF));
  x0_id_fwd2: assert property (@(posedge CLK) disable iff (reset)
                               (id_rs2 == '0) |-> (id_fwd2 == core_pkg::FWD_RF));
  x0_fwd1: assert property (@(posedge CLK) disable iff (reset)
                            (id_rs1 == '0) |=> (ex_fwd1 == core_pkg::FWD_RF));
  x0_fwd2: assert property (@(posedge CLK) disable iff (reset)
                            (id_rs2 == '0) |=> (ex_fwd2 == core_pkg::FWD_RF));

endmodule

`default_nettype wire

// File: source/instr_decoder.sv
`default_nettype none

module instr_decoder (
  input  wire core_pkg::word_t  inst,
  output core_pkg::reg_addr_t   rs1,
  output core_pkg::reg_addr_t   rs2,
  output core_pkg::reg_addr_t   rd,
  output core_pkg::word_t       imm,
  output core_pkg::alu_fn_t     alu_fn,
  output logic                  alu_src_imm,
  output logic                  uses_rs1,
  output logic                  uses_rs2,
  output logic                  reg_write,
  output logic                  mem_read,
  output logic                  mem_write,
  output core_pkg::br_type_t    br_type,
  output core_pkg::wb_from_t    wb_from
);

  logic [2:0] funct3;
  logic       wr;     // write intent before the x0 check

  assign rs1       = inst[19:15];
  assign rs2       = inst[24:20];
  assign rd        = inst[11:7];
  assign funct3    = inst[14:12];
  assign reg_write = wr && (rd != '0);

  always_comb
  begin
    imm         = '0;
    alu_fn      = core_pkg::ALU_ADD;
    alu_src_imm = 1'b0;
    uses_rs1    = 1'b0;
    uses_rs2    = 1'b0;
    wr          = 1'b0;
    mem_read    = 1'b0;
    mem_write   = 1'b0;
    br_type     = core_pkg::BR_NONE;
    wb_from     = core_pkg::WB_ALU;
    case (inst[6:0])
      core_pkg::OP_LUI:
      begin
        imm         = {inst[31:12], 12'b0};
        alu_fn      = core_pkg::ALU_PASS2;
        alu_src_imm = 1'b1;
        wr          = 1'b1;
      end
      core_pkg::OP_IMM:
      begin
        imm         = {{20{inst[31]}}, inst[31:20]};
        alu_src_imm = 1'b1;
        uses_rs1    = 1'b1;
        wr          = (funct3 == 3'b000);   // addi only
      end
      core_pkg::OP_REG:
      begin
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        wr       = 1'b1;
        case (funct3)
          3'b000:  alu_fn = inst[30] ? core_pkg::ALU_SUB : core_pkg::ALU_ADD;
          3'b010:  alu_fn = core_pkg::ALU_SLT;
          3'b100:  alu_fn = core_pkg::ALU_XOR;
          3'b110:  alu_fn = core_pkg::ALU_OR;
          3'b111:  alu_fn = core_pkg::ALU_AND;
          default: wr = 1'b0;   // shifts and sltu are not decoded
        endcase
      end
      core_pkg::OP_LOAD:
      begin
        imm         = {{20{inst[31]}}, inst[31:20]};
        alu_src_imm = 1'b1;
        uses_rs1    = 1'b1;
        wr          = 1'b1;
        mem_read    = 1'b1;
        wb_from     = core_pkg::WB_MEM;
      end
      core_pkg::OP_STORE:
      begin
        imm         = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        alu_src_imm = 1'b1;
        uses_rs1    = 1'b1;
        uses_rs2    = 1'b1;   // store data
        mem_write   = 1'b1;
      end
      core_pkg::OP_BRANCH:
      begin
        imm      = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        case (funct3)
          3'b000:  br_type = core_pkg::BR_EQ;
          3'b001:  br_type = core_pkg::BR_NE;
          3'b100:  br_type = core_pkg::BR_LT;
          default: br_type = core_pkg::BR_NONE;
        endcase
      end
      core_pkg::OP_JAL:
      begin
        imm     = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        br_type = core_pkg::BR_J;
        wr      = 1'b1;
        wb_from = core_pkg::WB_LINK;
      end
      default: ;    // unknown opcode behaves as a nop
    endcase
  end

endmodule

`default_nettype wire

// File: source/fetch_stage.sv
`default_nettype none

module fetch_stage (
  input  wire                   CLK,
  input  wire                   reset,
  input  wire                   stall,
  input  wire                   redirect,
  input  wire core_pkg::word_t  redirect_pc,
  input  wire core_pkg::word_t  i_mem_data,
  output core_pkg::word_t       i_mem_addr,
  output core_pkg::word_t       if_id_inst,
  output core_pkg::word_t       if_id_pc
);

  core_pkg::word_t pc;

  assign i_mem_addr = pc;

  // stall wins over redirect, so a stalled branch is resolved again later
  always_ff @(posedge CLK)
  begin
    if (reset)
    begin
      pc         <= core_pkg::RESET_PC;
      if_id_inst <= core_pkg::NOP_INST;
    end
    else if (!stall)
    begin
      if (redirect)
      begin
        pc         <= redirect_pc;
        if_id_inst <= core_pkg::NOP_INST;   // squash the wrong-path fetch
      end
      else
      begin
        pc         <= pc + 32'd4;
        if_id_inst <= i_mem_data;
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (!stall)
      if_id_pc <= pc;
  end

  // branch and jump targets from decode must keep the pc aligned
  pc_aligned: assert property (@(posedge CLK) disable iff (reset) pc[1:0] == 2'b00)
    else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

// File: source/core_pkg.sv
`default_nettype none

package core_pkg;

  typedef logic [31:0] word_t;      // data, address and instruction word
  typedef logic [4:0]  reg_addr_t;
  typedef logic [2:0]  alu_fn_t;
  typedef logic [1:0]  fwd_sel_t;   // where an operand is taken from
  typedef logic [2:0]  br_type_t;
  typedef logic [1:0]  wb_from_t;

  // major opcodes of the kept instructions
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_JAL    = 7'b1101111;

  localparam alu_fn_t ALU_ADD   = 3'd0;
  localparam alu_fn_t ALU_SUB   = 3'd1;
  localparam alu_fn_t ALU_AND   = 3'd2;
  localparam alu_fn_t ALU_OR    = 3'd3;
  localparam alu_fn_t ALU_XOR   = 3'd4;
  localparam alu_fn_t ALU_SLT   = 3'd5;
  localparam alu_fn_t ALU_PASS2 = 3'd6;   // result is operand 2, used by lui

  localparam fwd_sel_t FWD_RF  = 2'd0;    // value read in decode
  localparam fwd_sel_t FWD_EX  = 2'd1;
  localparam fwd_sel_t FWD_MEM = 2'd2;
  localparam fwd_sel_t FWD_WB  = 2'd3;

  localparam br_type_t BR_NONE = 3'd0;
  localparam br_type_t BR_EQ   = 3'd1;
  localparam br_type_t BR_NE   = 3'd2;
  localparam br_type_t BR_LT   = 3'd3;
  localparam br_type_t BR_J    = 3'd4;

  localparam wb_from_t WB_ALU  = 2'd0;
  localparam wb_from_t WB_MEM  = 2'd1;
  localparam wb_from_t WB_LINK = 2'd2;    // pc + 4 of a jal

  localparam word_t NOP_INST = 32'h0000_0013;  // addi x0, x0, 0
  localparam word_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire
